//--- cpuPkg.sv
package cpuPkg;

    // Data and index widths
    typedef logic [31:0] word_t;
    typedef logic [3:0]  regIdx_t;
    typedef logic [8:0]  ramAddr_t;
    typedef logic [4:0]  opcode_t;

    // Drivers of the single shared bus
    typedef enum logic [2:0] {
        busNone, busPc, busMdr, busZ, busReg, busImm
    } busSrc_t;

    // ALU functions, B is the bus side
    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluPassB
    } aluOp_t;

    // Sequencer phases
    typedef enum logic [3:0] {
        phIdle, phT0, phT1, phT2, phT3, phT4, phT5, phT6, phT7
    } phase_t;

    // Opcode values
    localparam opcode_t OpLd   = 5'h00;
    localparam opcode_t OpSt   = 5'h01;
    localparam opcode_t OpAdd  = 5'h03;
    localparam opcode_t OpSub  = 5'h04;
    localparam opcode_t OpAnd  = 5'h05;
    localparam opcode_t OpOr   = 5'h06;
    localparam opcode_t OpAddi = 5'h0C;
    localparam opcode_t OpHalt = 5'h1B;

    // Instruction field positions
    localparam int OpMsb = 31;
    localparam int OpLsb = 27;
    localparam int RaMsb = 26;
    localparam int RaLsb = 23;
    localparam int RbMsb = 22;
    localparam int RbLsb = 19;
    localparam int RcMsb = 18;
    localparam int RcLsb = 15;
    // C is bits 18 down to 0, sign bit on top
    localparam int CMsb  = 18;

    // Register field select codes
    localparam logic [1:0] SelRa = 2'd0;
    localparam logic [1:0] SelRb = 2'd1;
    localparam logic [1:0] SelRc = 2'd2;

    // APB map, RAM at bytes 0 to 0x7FC, control word above it
    localparam int          RamWords = 512;
    localparam logic [11:0] CtrlAddr = 12'h800;

endpackage

//--- controlUnit.sv
`timescale 1ns/1ps
module controlUnit (
    input  logic            Clock,
    input  logic            rstN,
    input  logic            start,
    input  cpuPkg::opcode_t opcode,
    output logic            running,
    output logic            halted,
    output cpuPkg::busSrc_t busSel,
    output logic [1:0]      regSel,
    output logic            baOut,
    output logic            marLoad,
    output logic            mdrLoadBus,
    output logic            mdrLoadRam,
    output logic            ramWrite,
    output logic            pcLoad,
    output logic            pcClear,
    output logic            irLoad,
    output logic            yLoad,
    output logic            zLoad,
    output logic            regLoad,
    output cpuPkg::aluOp_t  aluOp
);
    import cpuPkg::*;

    phase_t phase;
    phase_t phaseNext;
    logic   isRegOp;
    logic   isMemOp;
    logic   isHalt;

    // Instruction classes
    assign isRegOp = (opcode == OpAdd) || (opcode == OpSub) ||
                     (opcode == OpAnd) || (opcode == OpOr);
    assign isMemOp = (opcode == OpLd) || (opcode == OpSt);
    // Undefined opcodes stop the machine like halt
    assign isHalt  = (opcode == OpHalt) || !(isRegOp || isMemOp || (opcode == OpAddi));

    assign running = (phase != phIdle);

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            phase  <= phIdle;
            halted <= 1'b0;
        end else begin
            phase <= phaseNext;
            // Sticky until the next start
            if (start && phase == phIdle) begin
                halted <= 1'b0;
            end else if (phase == phT3 && isHalt) begin
                halted <= 1'b1;
            end
        end
    end

    always_comb begin
        phaseNext  = phase;
        busSel     = busNone;
        regSel     = SelRa;
        aluOp      = aluPassB;
        baOut      = 1'b0;
        marLoad    = 1'b0;
        mdrLoadBus = 1'b0;
        mdrLoadRam = 1'b0;
        ramWrite   = 1'b0;
        pcLoad     = 1'b0;
        pcClear    = 1'b0;
        irLoad     = 1'b0;
        yLoad      = 1'b0;
        zLoad      = 1'b0;
        regLoad    = 1'b0;
        case (phase)
            phIdle: begin
                // PC clears on the edge that leaves idle
                if (start) begin
                    pcClear   = 1'b1;
                    phaseNext = phT0;
                end
            end
            phT0: begin
                busSel    = busPc;
                marLoad   = 1'b1;
                pcLoad    = 1'b1;
                phaseNext = phT1;
            end
            phT1: begin
                mdrLoadRam = 1'b1;
                phaseNext  = phT2;
            end
            phT2: begin
                busSel    = busMdr;
                irLoad    = 1'b1;
                phaseNext = phT3;
            end
            phT3: begin
                if (isHalt) begin
                    phaseNext = phIdle;
                end else begin
                    // Base operand with R0 read as zero
                    busSel    = busReg;
                    regSel    = SelRb;
                    baOut     = 1'b1;
                    yLoad     = 1'b1;
                    phaseNext = phT4;
                end
            end
            phT4: begin
                zLoad     = 1'b1;
                phaseNext = phT5;
                if (isRegOp) begin
                    busSel = busReg;
                    regSel = SelRc;
                    case (opcode)
                        OpSub:   aluOp = aluSub;
                        OpAnd:   aluOp = aluAnd;
                        OpOr:    aluOp = aluOr;
                        default: aluOp = aluAdd;
                    endcase
                end else begin
                    // addi and effective address
                    busSel = busImm;
                    aluOp  = aluAdd;
                end
            end
            phT5: begin
                busSel = busZ;
                if (isMemOp) begin
                    marLoad   = 1'b1;
                    phaseNext = phT6;
                end else begin
                    regLoad   = 1'b1;
                    phaseNext = phT0;
                end
            end
            phT6: begin
                phaseNext = phT7;
                if (opcode == OpLd) begin
                    mdrLoadRam = 1'b1;
                end else begin
                    // Store data from Ra
                    busSel     = busReg;
                    mdrLoadBus = 1'b1;
                end
            end
            phT7: begin
                phaseNext = phT0;
                if (opcode == OpLd) begin
                    busSel  = busMdr;
                    regLoad = 1'b1;
                end else begin
                    ramWrite = 1'b1;
                end
            end
            default: phaseNext = phIdle;
        endcase
    end

    // MDR loads right after MAR takes an address and from the bus only for st
    mdrAfterMar: assert property (@(posedge Clock) disable iff (!rstN)
        (mdrLoadRam || mdrLoadBus) |-> ($past(marLoad) && (!mdrLoadBus || opcode == OpSt)));

endmodule

//--- instructionPath.sv
`timescale 1ns/1ps
module instructionPath (
    input  logic             Clock,
    input  logic             rstN,
    input  cpuPkg::busSrc_t  busSel,
    input  logic             pcLoad,
    input  logic             pcClear,
    input  logic             irLoad,
    input  cpuPkg::word_t    mdrOut,
    input  cpuPkg::word_t    zOut,
    input  cpuPkg::word_t    regOut,
    output cpuPkg::word_t    busData,
    output cpuPkg::opcode_t  opcode,
    output cpuPkg::regIdx_t  raIdx,
    output cpuPkg::regIdx_t  rbIdx,
    output cpuPkg::regIdx_t  rcIdx
);
    import cpuPkg::*;

    word_t pc;
    word_t ir;
    word_t cSext;

    // PC counts words; clear wins over increment
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            pc <= '0;
        end else if (pcClear) begin
            pc <= '0;
        end else if (pcLoad) begin
            pc <= pc + 32'd1;
        end
    end

    always_ff @(posedge Clock) begin
        if (irLoad) begin
            ir <= busData;
        end
    end

    // IR fields
    assign opcode = ir[OpMsb:OpLsb];
    assign raIdx  = ir[RaMsb:RaLsb];
    assign rbIdx  = ir[RbMsb:RbLsb];
    assign rcIdx  = ir[RcMsb:RcLsb];

    // C field, sign extended to a full word
    assign cSext = {{(31 - CMsb){ir[CMsb]}}, ir[CMsb:0]};

    // Shared bus multiplexer
    always_comb begin
        case (busSel)
            busPc:   busData = pc;
            busMdr:  busData = mdrOut;
            busZ:    busData = zOut;
            busReg:  busData = regOut;
            busImm:  busData = cSext;
            default: busData = '0;
        endcase
    end

    // Loading PC or IR needs a real bus driver
    busDriven: assert property (@(posedge Clock) disable iff (!rstN)
        (irLoad || (pcLoad && !pcClear)) |-> (busSel != busNone));

endmodule

//--- registerFile.sv
`timescale 1ns/1ps
module registerFile (
    input  logic            Clock,
    input  logic            rstN,
    input  cpuPkg::regIdx_t raIdx,
    input  cpuPkg::regIdx_t rbIdx,
    input  cpuPkg::regIdx_t rcIdx,
    input  logic [1:0]      regSel,
    input  logic            baOut,
    input  logic            regLoad,
    input  cpuPkg::word_t   busData,
    output cpuPkg::word_t   regOut
);
    import cpuPkg::*;

    word_t   regs [16];
    regIdx_t selIdx;

    // One field serves both read and write
    always_comb begin
        case (regSel)
            SelRb:   selIdx = rbIdx;
            SelRc:   selIdx = rcIdx;
            default: selIdx = raIdx;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (regLoad) begin
            regs[selIdx] <= busData;
        end
    end

    // BAout turns R0 into a zero base
    assign regOut = (baOut && selIdx == '0) ? '0 : regs[selIdx];

endmodule

//--- aluBlock.sv
`timescale 1ns/1ps
module aluBlock (
    input  logic           Clock,
    input  logic           rstN,
    input  cpuPkg::word_t  busData,
    input  logic           yLoad,
    input  logic           zLoad,
    input  cpuPkg::aluOp_t aluOp,
    output cpuPkg::word_t  zOut
);
    import cpuPkg::*;

    word_t y;
    word_t z;
    word_t aluResult;

    // Y holds the A operand across the bus cycle
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            y <= '0;
        end else if (yLoad) begin
            y <= busData;
        end
    end

    // A is Y, B is the live bus
    always_comb begin
        case (aluOp)
            aluAdd:  aluResult = y + busData;
            aluSub:  aluResult = y - busData;
            aluAnd:  aluResult = y & busData;
            aluOr:   aluResult = y | busData;
            default: aluResult = busData;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            z <= '0;
        end else if (zLoad) begin
            z <= aluResult;
        end
    end

    assign zOut = z;

endmodule

//--- memoryUnit.sv
`timescale 1ns/1ps
module memoryUnit (
    input  logic          Clock,
    input  logic          rstN,
    input  cpuPkg::word_t busData,
    input  logic          marLoad,
    input  logic          mdrLoadBus,
    input  logic          mdrLoadRam,
    input  logic          ramWrite,
    input  logic          running,
    input  logic          halted,
    output cpuPkg::word_t mdrOut,
    output logic          start,
    input  logic          pSel,
    input  logic          pEnable,
    input  logic          pWrite,
    input  logic [11:0]   pAddr,
    input  cpuPkg::word_t pWData,
    output cpuPkg::word_t pRData,
    output logic          pReady
);
    import cpuPkg::*;

    word_t    ram [RamWords];
    ramAddr_t mar;
    word_t    mdr;
    ramAddr_t apbWordAddr;
    logic     ramHit;
    logic     ctrlHit;
    logic     apbDone;
    logic     apbRamWrite;

    // Address decode, byte address to word index
    assign ramHit      = (pAddr < CtrlAddr);
    assign ctrlHit     = (pAddr == CtrlAddr);
    assign apbWordAddr = pAddr[10:2];

    // RAM waits for the processor, control word never does
    assign pReady      = !(pSel && ramHit && running);
    assign apbDone     = pSel && pEnable && pReady;
    assign apbRamWrite = apbDone && pWrite && ramHit;

    // MAR keeps the low word address bits of the bus
    always_ff @(posedge Clock) begin
        if (marLoad) begin
            mar <= busData[8:0];
        end
    end

    always_ff @(posedge Clock) begin
        if (mdrLoadRam) begin
            mdr <= ram[mar];
        end else if (mdrLoadBus) begin
            mdr <= busData;
        end
    end

    assign mdrOut = mdr;

    // Processor and APB never write in the same cycle
    always_ff @(posedge Clock) begin
        if (ramWrite) begin
            ram[mar] <= mdr;
        end else if (apbRamWrite) begin
            ram[apbWordAddr] <= pWData;
        end
    end

    // Start pulse, only accepted while idle
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            start <= 1'b0;
        end else begin
            start <= apbDone && pWrite && ctrlHit && pWData[0] && !running;
        end
    end

    // Status is bit 0 running, bit 1 halted
    always_comb begin
        if (ctrlHit) begin
            pRData = {30'd0, halted, running};
        end else if (ramHit) begin
            pRData = ram[apbWordAddr];
        end else begin
            pRData = '0;
        end
    end

    // Back-pressure keeps APB writes out of a run
    noWriteClash: assert property (@(posedge Clock) disable iff (!rstN)
        ramWrite |-> !apbRamWrite);

endmodule

//--- cpuTop.sv
`timescale 1ns/1ps
module cpuTop (
    input  logic          Clock,
    input  logic          rstN,
    input  logic          pSel,
    input  logic          pEnable,
    input  logic          pWrite,
    input  logic [11:0]   pAddr,
    input  cpuPkg::word_t pWData,
    output cpuPkg::word_t pRData,
    output logic          pReady
);
    import cpuPkg::*;

    // Shared bus and block outputs
    word_t   busData;
    word_t   mdrOut;
    word_t   zOut;
    word_t   regOut;

    // IR fields
    opcode_t opcode;
    regIdx_t raIdx;
    regIdx_t rbIdx;
    regIdx_t rcIdx;

    // Control word from the sequencer
    busSrc_t    busSel;
    aluOp_t     aluOp;
    logic [1:0] regSel;
    logic       baOut;
    logic       marLoad;
    logic       mdrLoadBus;
    logic       mdrLoadRam;
    logic       ramWrite;
    logic       pcLoad;
    logic       pcClear;
    logic       irLoad;
    logic       yLoad;
    logic       zLoad;
    logic       regLoad;

    // Run control
    logic start;
    logic running;
    logic halted;

    controlUnit controlUnit_i (
        .Clock(Clock), .rstN(rstN), .start(start), .opcode(opcode),
        .running(running), .halted(halted), .busSel(busSel), .regSel(regSel),
        .baOut(baOut), .marLoad(marLoad), .mdrLoadBus(mdrLoadBus),
        .mdrLoadRam(mdrLoadRam), .ramWrite(ramWrite), .pcLoad(pcLoad),
        .pcClear(pcClear), .irLoad(irLoad), .yLoad(yLoad), .zLoad(zLoad),
        .regLoad(regLoad), .aluOp(aluOp)
    );

    instructionPath instructionPath_i (
        .Clock(Clock), .rstN(rstN), .busSel(busSel), .pcLoad(pcLoad),
        .pcClear(pcClear), .irLoad(irLoad), .mdrOut(mdrOut), .zOut(zOut),
        .regOut(regOut), .busData(busData), .opcode(opcode),
        .raIdx(raIdx), .rbIdx(rbIdx), .rcIdx(rcIdx)
    );

    registerFile registerFile_i (
        .Clock(Clock), .rstN(rstN), .raIdx(raIdx), .rbIdx(rbIdx), .rcIdx(rcIdx),
        .regSel(regSel), .baOut(baOut), .regLoad(regLoad), .busData(busData),
        .regOut(regOut)
    );

    aluBlock aluBlock_i (
        .Clock(Clock), .rstN(rstN), .busData(busData), .yLoad(yLoad),
        .zLoad(zLoad), .aluOp(aluOp), .zOut(zOut)
    );

    memoryUnit memoryUnit_i (
        .Clock(Clock), .rstN(rstN), .busData(busData), .marLoad(marLoad),
        .mdrLoadBus(mdrLoadBus), .mdrLoadRam(mdrLoadRam), .ramWrite(ramWrite),
        .running(running), .halted(halted), .mdrOut(mdrOut), .start(start),
        .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite), .pAddr(pAddr),
        .pWData(pWData), .pRData(pRData), .pReady(pReady)
    );

endmodule

//--- tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Word addresses that the programs touch
localparam ramAddr_t ResultBase = 9'h100;
localparam ramAddr_t SrcZero    = 9'h180;
localparam ramAddr_t CopyZero   = 9'h188;
localparam ramAddr_t SrcBased   = 9'h1C0;
localparam ramAddr_t CopyBased  = 9'h1C8;
localparam ramAddr_t MarkerA    = 9'h1F0;
localparam ramAddr_t MarkerB    = 9'h1F4;
// Base register value for the negative offsets
localparam int       BaseValue  = 'h1D0;

// Register format: opcode, Ra, Rb, Rc, unused low bits
function automatic word_t encReg(input opcode_t op, input int ra, input int rb, input int rc);
    return {op, ra[3:0], rb[3:0], rc[3:0], 15'd0};
endfunction

// Immediate format: opcode, Ra, Rb, 19-bit C
function automatic word_t encImm(input opcode_t op, input int ra, input int rb, input int c);
    return {op, ra[3:0], rb[3:0], c[18:0]};
endfunction

function automatic word_t encHalt();
    return {OpHalt, 27'd0};
endfunction

// R1 and R2 from immediates, R3 to R6 from the register ops, all stored
task automatic arithProgram(input logic [18:0] immA, input logic [18:0] immB);
    progWords.delete();
    progWords.push_back(encImm(OpAddi, 1, 0, int'(immA)));
    progWords.push_back(encImm(OpAddi, 2, 0, int'(immB)));
    progWords.push_back(encReg(OpAdd, 3, 1, 2));
    progWords.push_back(encReg(OpSub, 4, 1, 2));
    progWords.push_back(encReg(OpAnd, 5, 1, 2));
    progWords.push_back(encReg(OpOr, 6, 1, 2));
    for (int k = 0; k < 6; k++) begin
        progWords.push_back(encImm(OpSt, k + 1, 0, int'(ResultBase) + k));
    end
    progWords.push_back(encHalt());
    // Sits behind halt, must never run
    progWords.push_back(encImm(OpSt, 1, 0, int'(MarkerA)));
endtask

// R0 made nonzero first so the zero base rule is visible
task automatic memProgram();
    progWords.delete();
    progWords.push_back(encImm(OpAddi, 0, 0, 'h55));
    progWords.push_back(encImm(OpLd, 7, 0, int'(SrcZero)));
    progWords.push_back(encImm(OpSt, 7, 0, int'(CopyZero)));
    progWords.push_back(encImm(OpAddi, 8, 0, BaseValue));
    progWords.push_back(encImm(OpLd, 9, 8, int'(SrcBased) - BaseValue));
    progWords.push_back(encImm(OpSt, 9, 8, int'(CopyBased) - BaseValue));
    progWords.push_back(encHalt());
    progWords.push_back(encImm(OpSt, 9, 0, int'(MarkerB)));
endtask

`endif

//--- tb.sv
`timescale 1ns/1ps
module tb;
    import cpuPkg::*;

    localparam int       ClockPeriod = 4;
    localparam int       ResetCycles = 5;
    localparam int       RandomPairs = 16;
    // RAM word read only to wait for halt
    localparam ramAddr_t ProbeAddr   = 9'h1FF;
    // Run length estimate in clocks
    localparam int ApbCycles      = 3;
    localparam int MaxAccesses    = 160;
    localparam int MaxRunCycles   = 3 * 16 * 8;
    localparam int MarginCycles   = 200;
    localparam int WatchdogCycles = ResetCycles + MaxAccesses * ApbCycles +
                                    MaxRunCycles + MarginCycles;

    logic        Clock;
    logic        rstN;
    logic        pSel;
    logic        pEnable;
    logic        pWrite;
    logic [11:0] pAddr;
    word_t       pWData;
    word_t       pRData;
    logic        pReady;

    logic [31:0] lfsrState;
    word_t       progWords [$];
    word_t       shadow [RamWords];
    int          testErrors;
    int          testsPassed;
    int          testsFailed;

    `include "tbProgram.svh"

    cpuTop cpuTop_i (
        .Clock(Clock), .rstN(rstN), .pSel(pSel), .pEnable(pEnable),
        .pWrite(pWrite), .pAddr(pAddr), .pWData(pWData), .pRData(pRData),
        .pReady(pReady)
    );

    initial begin
        Clock = 1'b0;
        forever #(ClockPeriod / 2) Clock = ~Clock;
    end

    initial begin
        #(WatchdogCycles * ClockPeriod);
        $display("watchdog expired after %0d cycles, the run did not finish", WatchdogCycles);
        $display("TEST FAIL");
        $finish;
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic word_t randomBits(input int n);
        word_t value;
        logic  feedback;
        value = '0;
        for (int i = 0; i < n; i++) begin
            feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            value     = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic [11:0] byteAddr(input ramAddr_t w);
        return {1'b0, w, 2'b00};
    endfunction

    function automatic word_t signExtend19(input logic [18:0] v);
        return {{13{v[18]}}, v};
    endfunction

    // One APB transfer that counts the access cycles spent waiting
    task automatic apbTransfer(input logic wr, input logic [11:0] addr, input word_t wdata,
                               output word_t rdata, output int waits);
        @(negedge Clock);
        pSel    = 1'b1;
        pWrite  = wr;
        pAddr   = addr;
        pWData  = wdata;
        pEnable = 1'b0;
        @(negedge Clock);
        pEnable = 1'b1;
        waits   = 0;
        // Sampled mid-cycle where pReady and pRData are settled
        #1;
        while (!pReady) begin
            @(negedge Clock);
            #1;
            waits++;
        end
        rdata = pRData;
        @(negedge Clock);
        pSel    = 1'b0;
        pEnable = 1'b0;
        pWrite  = 1'b0;
    endtask

    task automatic apbWrite(input logic [11:0] addr, input word_t data);
        word_t ignoredData;
        int    ignoredWaits;
        apbTransfer(1'b1, addr, data, ignoredData, ignoredWaits);
    endtask

    task automatic apbRead(input logic [11:0] addr, output word_t data);
        int ignoredWaits;
        apbTransfer(1'b0, addr, '0, data, ignoredWaits);
    endtask

    task automatic expectWord(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("Fail %s got 0x%08h expected 0x%08h", name, got, exp);
            testErrors++;
        end
    endtask

    task automatic expectTrue(input bit cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            testErrors++;
        end
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0) begin
            $display("%s passed", name);
            testsPassed++;
        end else begin
            $display("%s failed with %0d errors", name, testErrors);
            testsFailed++;
        end
        testErrors = 0;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < progWords.size(); i++) begin
            apbWrite(byteAddr(ramAddr_t'(i)), progWords[i]);
        end
    endtask

    // Start followed by a RAM read that stalls until halt
    task automatic runUntilHalt();
        word_t ignoredData;
        apbWrite(CtrlAddr, 32'h1);
        apbRead(byteAddr(ProbeAddr), ignoredData);
    endtask

    initial begin
        word_t       data;
        word_t       wdata;
        word_t       markerWordA;
        word_t       markerWordB;
        word_t       src1;
        word_t       src2;
        word_t       a;
        word_t       b;
        word_t       expected [6];
        ramAddr_t    addrs [RandomPairs];
        logic [18:0] immA;
        logic [18:0] immB;
        int          waits;
        rstN        = 1'b0;
        pSel        = 1'b0;
        pEnable     = 1'b0;
        pWrite      = 1'b0;
        pAddr       = '0;
        pWData      = '0;
        lfsrState   = 32'd72275;
        testErrors  = 0;
        testsPassed = 0;
        testsFailed = 0;
        repeat (ResetCycles) @(negedge Clock);
        rstN = 1'b1;

        // Idle status and no wait state on a RAM access
        apbTransfer(1'b0, byteAddr(ProbeAddr), '0, data, waits);
        expectTrue(waits == 0, "RAM read right after reset was held off");
        apbRead(CtrlAddr, data);
        expectWord("pRData status", data, 32'h0);
        finishTest("test 1 reset state");

        // Immediate read back and then a second pass over all words
        for (int i = 0; i < RandomPairs; i++) begin
            addrs[i] = ramAddr_t'(randomBits(9));
            wdata    = randomBits(32);
            shadow[addrs[i]] = wdata;
            apbWrite(byteAddr(addrs[i]), wdata);
            apbRead(byteAddr(addrs[i]), data);
            expectWord($sformatf("pRData ram[0x%03h]", addrs[i]), data, wdata);
        end
        for (int i = 0; i < RandomPairs; i++) begin
            apbRead(byteAddr(addrs[i]), data);
            expectWord($sformatf("pRData ram[0x%03h]", addrs[i]), data, shadow[addrs[i]]);
        end
        finishTest("test 2 APB RAM access");

        // Arithmetic program
        immA        = 19'(randomBits(19));
        immB        = 19'(randomBits(19));
        a           = signExtend19(immA);
        b           = signExtend19(immB);
        expected[0] = a;
        expected[1] = b;
        expected[2] = a + b;
        expected[3] = a - b;
        expected[4] = a & b;
        expected[5] = a | b;
        markerWordA = randomBits(32);
        arithProgram(immA, immB);
        loadProgram();
        // Result words preset to something the program must overwrite
        for (int k = 0; k < 6; k++) begin
            apbWrite(byteAddr(ramAddr_t'(ResultBase + k)), ~expected[k]);
        end
        apbWrite(byteAddr(MarkerA), markerWordA);
        runUntilHalt();
        for (int k = 0; k < 6; k++) begin
            apbRead(byteAddr(ramAddr_t'(ResultBase + k)), data);
            expectWord($sformatf("pRData result R%0d", k + 1), data, expected[k]);
        end
        finishTest("test 3 ALU program");

        // Loads and stores with zero base and negative offsets
        src1        = randomBits(32);
        src2        = randomBits(32);
        markerWordB = randomBits(32);
        memProgram();
        loadProgram();
        apbWrite(byteAddr(SrcZero), src1);
        apbWrite(byteAddr(SrcBased), src2);
        apbWrite(byteAddr(CopyZero), ~src1);
        apbWrite(byteAddr(CopyBased), ~src2);
        apbWrite(byteAddr(MarkerB), markerWordB);
        runUntilHalt();
        apbRead(byteAddr(CopyZero), data);
        expectWord("pRData copy via R0 base", data, src1);
        apbRead(byteAddr(CopyBased), data);
        expectWord("pRData copy via R8 base", data, src2);
        finishTest("test 4 load and store");

        // Same program again while watching the handshake
        apbWrite(CtrlAddr, 32'h1);
        apbTransfer(1'b0, CtrlAddr, '0, data, waits);
        expectWord("pRData status while running", data, 32'h1);
        expectTrue(waits == 0, "control word read stalled while the processor ran");
        apbTransfer(1'b0, byteAddr(ProbeAddr), '0, data, waits);
        expectTrue(waits > 0, "RAM read during the run completed without waiting");
        apbRead(CtrlAddr, data);
        expectWord("pRData status after stall", data, 32'h2);
        finishTest("test 5 back-pressure");

        // Stores behind halt left the markers alone
        apbRead(byteAddr(MarkerA), data);
        expectWord("pRData marker A", data, markerWordA);
        apbRead(byteAddr(MarkerB), data);
        expectWord("pRData marker B", data, markerWordB);
        finishTest("test 6 halt stops fetch");

        $display("tests passed %0d failed %0d", testsPassed, testsFailed);
        if (testsFailed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
cpuPkg.sv
controlUnit.sv
instructionPath.sv
registerFile.sv
aluBlock.sv
memoryUnit.sv
cpuTop.sv
tb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb -f tb.f -o simTb \
    && simOut="$(./obj_dir/simTb)" \
    && printf '%s\n' "$simOut" \
    && grep -qx "TEST PASS" <<< "$simOut" \
    && echo "simulation passed" \
    || { printf '%s\n' "${simOut:-}"; echo "simulation failed"; exit 1; }
